// File: rtl/conf_store.sv
`timescale 1ns/100ps

module conf_store
    import pov_types_pkg::*;
#(
    parameter conf_word_t DEFAULT_CONF = '0
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic       conf_load,
    input  conf_word_t conf_data,
    output logic       new_conf,
    output conf_word_t active_conf
);

    // Set by reset so the default gets written once
    logic boot_pending;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            active_conf <= DEFAULT_CONF;
            boot_pending <= 1'b1;
            new_conf <= 1'b0;
        end else begin
            // One-cycle announce after reset or a host load
            new_conf <= boot_pending | conf_load;
            boot_pending <= 1'b0;
            if (conf_load) begin
                active_conf <= conf_data;
            end
        end
    end

endmodule

// File: rtl/driver_controller.sv
`timescale 1ns/100ps

module driver_controller
    import pov_types_pkg::*;
    import tlc_timing_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        clk_enable,
    input  logic        new_conf,
    input  conf_word_t  active_conf,
    input  logic        position_sync,
    fb_bus_if.requester fb,
    output logic        drv_sclk,
    output logic        drv_gclk,
    output logic        drv_lat,
    output lane_word_t  drv_sin,
    output logic        column_ready,
    output logic        streaming
);

    // Boot runs STALL, FCWRTEN, conf shift with WRTFC, settle
    // Afterwards it alternates between waiting and streaming
    typedef enum logic [2:0] {
        ST_STALL,
        ST_PREPARE_CONFIG,
        ST_CONFIG,
        ST_WRTFC_WAIT,
        ST_WAIT_FOR_SLICE,
        ST_STREAM
    } state_t;

    state_t state;

    // In-state counter during boot, bit position inside a group while streaming
    logic [5:0] bit_cnt;
    // Group within the segment, SHIFTS_PER_SEG means all shifts done
    logic [3:0] grp_cnt;
    // GCLK segment position including the pause cycle
    logic [9:0] seg_cnt;
    logic [2:0] row_cnt;
    // Next framebuffer word to be shifted
    fb_addr_t addr_cnt;
    logic stop_gclk;

    logic in_region;
    logic shift_pos;
    logic shift_now;
    logic slice_start;

    // Shift area of the segment after blanking
    assign in_region = (state == ST_STREAM) && (seg_cnt >= BLANK_LEN)
                       && (grp_cnt < SHIFTS_PER_SEG);
    // Bit 0 of each group is the pause after a latch
    assign shift_pos = in_region && (bit_cnt != '0);
    assign shift_now = clk_enable && shift_pos;
    assign slice_start = (state == ST_WAIT_FOR_SLICE) && position_sync;

    // Strobes are taken on any cycle, counters move on enabled cycles only
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= ST_STALL;
            bit_cnt <= '0;
            grp_cnt <= '0;
            row_cnt <= '0;
            addr_cnt <= '0;
        end else if (new_conf) begin
            state <= ST_PREPARE_CONFIG;
            bit_cnt <= '0;
        end else if (slice_start) begin
            state <= ST_STREAM;
            bit_cnt <= '0;
            grp_cnt <= '0;
            row_cnt <= '0;
            addr_cnt <= '0;
        end else if (clk_enable) begin
            case (state)
                ST_PREPARE_CONFIG: begin
                    // FCWRTEN
                    if (bit_cnt == FCWRTEN_LEN - 1) begin
                        state <= ST_CONFIG;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                ST_CONFIG: begin
                    // Pause plus 48 conf bits
                    if (bit_cnt == SHIFT_BITS) begin
                        state <= ST_WRTFC_WAIT;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                ST_WRTFC_WAIT: begin
                    if (bit_cnt == WRTFC_WAIT - 1) begin
                        state <= ST_WAIT_FOR_SLICE;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                ST_STREAM: begin
                    if (in_region) begin
                        if (bit_cnt == GROUP_LEN - 1) begin
                            bit_cnt <= '0;
                            grp_cnt <= grp_cnt + 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    if (shift_pos) begin
                        addr_cnt <= addr_cnt + 1'b1;
                    end
                    // Segment wrap moves to the next row
                    if (seg_cnt == SEG_LAST) begin
                        bit_cnt <= '0;
                        grp_cnt <= '0;
                        row_cnt <= row_cnt + 1'b1;
                        if (row_cnt == ROWS - 1) begin
                            state <= ST_WAIT_FOR_SLICE;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // GCLK segment counter keeps running while waiting
    // After a slice it stops GCLK at the next wrap
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            seg_cnt <= '0;
            stop_gclk <= 1'b1;
        end else if (new_conf || slice_start) begin
            seg_cnt <= '0;
            stop_gclk <= !slice_start;
        end else if (state == ST_STREAM || state == ST_WAIT_FOR_SLICE) begin
            if (clk_enable) begin
                seg_cnt <= (seg_cnt == SEG_LAST) ? '0 : seg_cnt + 1'b1;
                if (state == ST_WAIT_FOR_SLICE && seg_cnt == SEG_LAST) begin
                    stop_gclk <= 1'b1;
                end
            end
        end else begin
            seg_cnt <= '0;
            stop_gclk <= 1'b1;
        end
    end

    // Clock and latch outputs follow clk_enable so each edge has a counter step
    always_comb begin
        drv_sclk = 1'b0;
        drv_lat = 1'b0;
        drv_sin = '0;
        case (state)
            ST_PREPARE_CONFIG: begin
                drv_sclk = clk_enable;
                drv_lat = clk_enable;
            end
            ST_CONFIG: begin
                if (bit_cnt != '0) begin
                    drv_sclk = clk_enable;
                    drv_sin = {$bits(lane_word_t){active_conf[SHIFT_BITS - bit_cnt]}};
                end
                // WRTFC on the last bits
                drv_lat = clk_enable && (bit_cnt > SHIFT_BITS - WRTFC_LEN);
            end
            ST_STREAM: begin
                drv_sclk = shift_now;
                if (shift_pos) begin
                    drv_sin = fb.rdata;
                end
                // WRTGS per group, LATGS closes the last group
                drv_lat = clk_enable && in_region
                          && ((bit_cnt > SHIFT_BITS - WRTGS_LEN)
                              || (grp_cnt == SHIFTS_PER_SEG - 1
                                  && bit_cnt > SHIFT_BITS - LATGS_LEN));
            end
            default: begin
            end
        endcase
    end

    // One pause cycle per segment for the LATGS to settle
    assign drv_gclk = clk_enable && (seg_cnt != '0)
                      && ((state == ST_STREAM)
                          || (state == ST_WAIT_FOR_SLICE && !stop_gclk));

    assign column_ready = clk_enable && (seg_cnt == SEG_LAST)
                          && (state == ST_STREAM || state == ST_WAIT_FOR_SLICE);
    assign streaming = (state == ST_STREAM);

    // Prefetch for the next shift cycle
    // Repeated through enable gaps so rdata stays on the word to shift
    assign fb.req = in_region && (clk_enable ? (bit_cnt != SHIFT_BITS) : (bit_cnt != '0));
    assign fb.addr = shift_now ? addr_cnt + 1'b1 : addr_cnt;
    assign fb.we = 1'b0;
    assign fb.wdata = '0;

    // Every word of the slice went out exactly once
    a_slice_words: assert property (
        @(posedge clk) disable iff (!nrst)
        (state == ST_STREAM && column_ready && row_cnt == ROWS - 1 && !new_conf)
        |-> (addr_cnt == FB_WORDS) ##1 (state == ST_WAIT_FOR_SLICE)
    );

endmodule

// File: rtl/fb_bus_if.sv
`timescale 1ns/100ps

interface fb_bus_if
    import pov_types_pkg::*;
();

    // Access strobe, one word per cycle
    logic req;
    // Write when high, read otherwise
    logic we;
    fb_addr_t addr;
    lane_word_t wdata;
    // Valid the cycle after the request
    lane_word_t rdata;

    // Side that issues accesses
    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    // Side that serves accesses
    modport memory (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// File: rtl/framebuffer_arbiter.sv
`timescale 1ns/100ps

module framebuffer_arbiter
    import pov_types_pkg::*;
(
    input  logic         clk,
    input  logic         nrst,
    fb_bus_if.memory     drv,
    fb_bus_if.requester  mem,
    input  logic         host_we,
    input  fb_addr_t     host_addr,
    input  lane_word_t   host_wdata,
    output logic         host_busy
);

    // Host has to hold its write while the driver reads
    assign host_busy = drv.req;

    // Fixed priority with the driver first
    always_comb begin
        if (drv.req) begin
            mem.req = 1'b1;
            mem.we = drv.we;
            mem.addr = drv.addr;
            mem.wdata = drv.wdata;
        end else begin
            mem.req = host_we;
            mem.we = host_we;
            mem.addr = host_addr;
            mem.wdata = host_wdata;
        end
    end

    // Only the driver sees read data
    assign drv.rdata = mem.rdata;

    // Driver side only ever reads, a write would corrupt the slice
    a_drv_read_only: assert property (
        @(posedge clk) disable iff (!nrst)
        drv.req |-> !drv.we
    );

endmodule

// File: rtl/framebuffer_ram.sv
`timescale 1ns/100ps

module framebuffer_ram
    import pov_types_pkg::*;
    import tlc_timing_pkg::*;
(
    input logic      clk,
    fb_bus_if.memory bus
);

    // One slice of bit-plane words, lane order within each word
    lane_word_t mem [FB_WORDS];

    // Address inside the slice
    logic addr_ok;

    assign addr_ok = (bus.addr < FB_WORDS);

    // Single port with registered read data
    // A write also returns the old word, nobody samples it
    always_ff @(posedge clk) begin
        if (bus.req && addr_ok) begin
            if (bus.we) begin
                mem[bus.addr] <= bus.wdata;
            end
            bus.rdata <= mem[bus.addr];
        end
    end

endmodule

// File: rtl/pov_display_top.sv
`timescale 1ns/100ps

module pov_display_top
    import pov_types_pkg::*;
#(
    parameter conf_word_t DEFAULT_CONF = 48'h8000_2A40_0321,
    parameter int DEAD_CYCLES = 1
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic       clk_enable,
    input  logic       position_sync,
    input  logic       conf_load,
    input  conf_word_t conf_data,
    input  logic       host_we,
    input  fb_addr_t   host_addr,
    input  lane_word_t host_wdata,
    output logic       host_busy,
    output logic       drv_sclk,
    output logic       drv_gclk,
    output logic       drv_lat,
    output lane_word_t drv_sin,
    output row_sel_t   row_en
);

    logic new_conf;
    conf_word_t active_conf;
    logic column_ready;
    logic streaming;

    // Controller to arbiter, arbiter to memory
    fb_bus_if drv_bus ();
    fb_bus_if ram_bus ();

    conf_store #(
        .DEFAULT_CONF (DEFAULT_CONF)
    ) u_conf_store (
        .clk         (clk),
        .nrst        (nrst),
        .conf_load   (conf_load),
        .conf_data   (conf_data),
        .new_conf    (new_conf),
        .active_conf (active_conf)
    );

    driver_controller u_driver_controller (
        .clk           (clk),
        .nrst          (nrst),
        .clk_enable    (clk_enable),
        .new_conf      (new_conf),
        .active_conf   (active_conf),
        .position_sync (position_sync),
        .fb            (drv_bus.requester),
        .drv_sclk      (drv_sclk),
        .drv_gclk      (drv_gclk),
        .drv_lat       (drv_lat),
        .drv_sin       (drv_sin),
        .column_ready  (column_ready),
        .streaming     (streaming)
    );

    framebuffer_arbiter u_framebuffer_arbiter (
        .clk        (clk),
        .nrst       (nrst),
        .drv        (drv_bus.memory),
        .mem        (ram_bus.requester),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_busy  (host_busy)
    );

    framebuffer_ram u_framebuffer_ram (
        .clk (clk),
        .bus (ram_bus.memory)
    );

    row_driver #(
        .DEAD_CYCLES (DEAD_CYCLES)
    ) u_row_driver (
        .clk          (clk),
        .nrst         (nrst),
        .column_ready (column_ready),
        .streaming    (streaming),
        .row_en       (row_en)
    );

endmodule

// File: rtl/pov_types_pkg.sv
package pov_types_pkg;

    // Parallel serial lanes in the driver chain
    localparam int LANES = 30;

    // Function control register length of one driver
    localparam int CONF_BITS = 48;

    // Word address width for 3072 framebuffer words
    localparam int FB_ADDR_BITS = 12;

    // Multiplexed rows behind the column drivers
    localparam int ROW_LINES = 8;

    // One SIN sample per lane
    // Also the width of a single framebuffer word
    typedef logic [LANES-1:0] lane_word_t;

    // Function control data, shifted out MSB first
    typedef logic [CONF_BITS-1:0] conf_word_t;

    // Framebuffer word address
    typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;

    // One enable per multiplexed row
    typedef logic [ROW_LINES-1:0] row_sel_t;

endpackage

// File: rtl/row_driver.sv
`timescale 1ns/100ps

module row_driver
    import pov_types_pkg::*;
    import tlc_timing_pkg::*;
#(
    parameter int DEAD_CYCLES = 1
) (
    input  logic     clk,
    input  logic     nrst,
    input  logic     column_ready,
    input  logic     streaming,
    output row_sel_t row_en
);

    localparam int DEAD_W = $clog2(DEAD_CYCLES + 1) + 1;

    logic [$clog2(ROWS)-1:0] row_idx;
    logic [DEAD_W-1:0] dead_cnt;
    logic streaming_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            row_en <= '0;
            row_idx <= '0;
            dead_cnt <= '0;
            streaming_q <= 1'b0;
        end else begin
            streaming_q <= streaming;
            if (streaming && !streaming_q) begin
                // Slice begins on row 0
                row_idx <= '0;
                row_en <= row_sel_t'(1);
                dead_cnt <= '0;
            end else if (column_ready) begin
                // Break before make
                row_en <= '0;
                dead_cnt <= DEAD_W'(DEAD_CYCLES);
            end else if (dead_cnt != '0) begin
                dead_cnt <= dead_cnt - 1'b1;
                // Stream over after the last segment leaves all rows off
                if (dead_cnt == 1 && streaming) begin
                    row_idx <= row_idx + 1'b1;
                    row_en <= row_sel_t'(1) << (row_idx + 1'b1);
                end
            end else if (!streaming) begin
                row_en <= '0;
            end
        end
    end

    // A new row may only follow a cycle with every row off
    a_row_break: assert property (
        @(posedge clk) disable iff (!nrst)
        (row_en != '0 && row_en != $past(row_en)) |-> ($past(row_en) == '0)
    );

endmodule

// File: rtl/tlc_timing_pkg.sv
package tlc_timing_pkg;

    // SCLK edges with LAT high for each latch command
    localparam int FCWRTEN_LEN = 15;
    localparam int WRTFC_LEN = 5;
    localparam int WRTGS_LEN = 1;
    localparam int LATGS_LEN = 3;

    // SCLK edges in one shift and shifts in one segment
    localparam int SHIFT_BITS = 48;
    localparam int SHIFTS_PER_SEG = 8;

    // 9-bit poker mode needs 512 GCLK plus one pause cycle
    localparam int SEG_LAST = 512;

    // Blanking at segment start keeps LATGS clear of the GCLK wrap
    localparam int BLANK_LEN = 72;

    // Pause cycle followed by one full shift
    localparam int GROUP_LEN = 49;

    // Multiplexed rows per slice
    localparam int ROWS = 8;

    // Settling time after WRTFC before streaming may begin
    localparam int WRTFC_WAIT = 6;

    // Framebuffer geometry
    localparam int WORDS_PER_SEG = 384;
    localparam int FB_WORDS = 3072;

endpackage

// File: src.f
+incdir+verification
rtl/pov_types_pkg.sv
rtl/tlc_timing_pkg.sv
rtl/fb_bus_if.sv
rtl/framebuffer_ram.sv
rtl/framebuffer_arbiter.sv
rtl/conf_store.sv
rtl/driver_controller.sv
rtl/row_driver.sv
rtl/pov_display_top.sv
verification/tb_pov_top.sv

// File: verification/tb_ref_model.svh
// LAT level expected on boot shift edge pos
// FCWRTEN first, then WRTFC on the tail of the conf shift
function automatic logic ref_boot_lat(input int pos);
    int bit_idx;
    bit_idx = pos - FCWRTEN_LEN;
    if (pos < FCWRTEN_LEN) begin
        return 1'b1;
    end
    return (bit_idx >= SHIFT_BITS - WRTFC_LEN);
endfunction

// Conf bit on boot shift edge pos, MSB leaves first
function automatic logic ref_boot_bit(input conf_word_t conf, input int pos);
    int bit_idx;
    bit_idx = pos - FCWRTEN_LEN;
    return conf[CONF_BITS - 1 - bit_idx];
endfunction

// LAT level on stream shift n of a slice
// WRTGS closes groups 0 to 6, LATGS spans the tail of group 7
function automatic logic ref_stream_lat(input int n);
    int bit_idx;
    int grp;
    bit_idx = n % SHIFT_BITS;
    grp = (n / SHIFT_BITS) % SHIFTS_PER_SEG;
    if (grp == SHIFTS_PER_SEG - 1) begin
        return (bit_idx >= SHIFT_BITS - LATGS_LEN);
    end
    return (bit_idx >= SHIFT_BITS - WRTGS_LEN);
endfunction

// Row enable for the k-th row of a slice
function automatic row_sel_t ref_row(input int k);
    return row_sel_t'(1) << (k % ROWS);
endfunction

task automatic check_lane(input string what, input lane_word_t exp, input lane_word_t act);
    if (act !== exp) begin
        report_failure($sformatf("MISMATCH %s %s: expected %h, actual %h",
                                 test_name, what, exp, act));
    end
endtask

task automatic check_conf_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        report_failure($sformatf("MISMATCH %s %s: expected %b, actual %b",
                                 test_name, what, exp, act));
    end
endtask

task automatic check_rows(input string what, input row_sel_t exp, input row_sel_t act);
    if (act !== exp) begin
        report_failure($sformatf("MISMATCH %s %s: expected %b, actual %b",
                                 test_name, what, exp, act));
    end
endtask

// Single control lines such as LAT and GCLK
task automatic check_level(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        report_failure($sformatf("MISMATCH %s %s: expected %b, actual %b",
                                 test_name, what, exp, act));
    end
endtask

// File: verification/tb_pov_top.sv
`timescale 1ns/100ps

module tb_pov_top
    import pov_types_pkg::*;
    import tlc_timing_pkg::*;
();

    localparam conf_word_t BOOT_CONF = 48'h8000_2A40_0321;

    // Kinds of expected shift edge
    localparam int MODE_CMD = 0;
    localparam int MODE_CONF = 1;
    localparam int MODE_WORD = 2;

    // Two boots and two slices at 3/4 enable plus the initial load, doubled
    localparam int BOOT_CYCLES = FCWRTEN_LEN + GROUP_LEN + WRTFC_WAIT + 1;
    localparam int SLICE_CYCLES = ROWS * (SEG_LAST + 1);
    localparam int TIMEOUT_CYCLES =
        2 * (FB_WORDS + (2 * BOOT_CYCLES + 2 * SLICE_CYCLES) * 4 / 3);

    logic clk = 1'b0;
    logic nrst;
    logic clk_enable = 1'b0;
    logic position_sync;
    logic conf_load;
    conf_word_t conf_data;
    logic host_we;
    fb_addr_t host_addr;
    lane_word_t host_wdata;
    logic host_busy;
    logic drv_sclk;
    logic drv_gclk;
    logic drv_lat;
    lane_word_t drv_sin;
    row_sel_t row_en;

    // Host view of the framebuffer contents
    lane_word_t fb_model [FB_WORDS];

    // Expected shift edges in order
    int exp_mode [$];
    lane_word_t exp_word [$];
    logic exp_lat [$];

    string test_name = "reset";
    int shown_cnt = 0;
    int rows_seen = 0;
    row_sel_t prev_row = '0;
    logic idle_watch = 1'b0;
    int cycle_cnt = 0;
    conf_word_t next_conf;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "Stopped at first error");
    endtask

    `include "tb_ref_model.svh"

    pov_display_top #(
        .DEFAULT_CONF (BOOT_CONF),
        .DEAD_CYCLES  (1)
    ) uut (
        .clk           (clk),
        .nrst          (nrst),
        .clk_enable    (clk_enable),
        .position_sync (position_sync),
        .conf_load     (conf_load),
        .conf_data     (conf_data),
        .host_we       (host_we),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .host_busy     (host_busy),
        .drv_sclk      (drv_sclk),
        .drv_gclk      (drv_gclk),
        .drv_lat       (drv_lat),
        .drv_sin       (drv_sin),
        .row_en        (row_en)
    );

    always #5 clk = ~clk;

    // Enable strobe, high on about 3 of 4 cycles
    always @(negedge clk) begin
        clk_enable <= (($urandom() % 4) != 0);
    end

    // FCWRTEN edges, then the conf shift with WRTFC
    task automatic push_boot(input conf_word_t conf);
        for (int i = 0; i < FCWRTEN_LEN + SHIFT_BITS; i++) begin
            if (i < FCWRTEN_LEN) begin
                exp_mode.push_back(MODE_CMD);
                exp_word.push_back('0);
            end else begin
                exp_mode.push_back(MODE_CONF);
                exp_word.push_back({LANES{ref_boot_bit(conf, i)}});
            end
            exp_lat.push_back(ref_boot_lat(i));
        end
    endtask

    // Whole slice in address order from the host copy
    task automatic push_slice();
        for (int n = 0; n < FB_WORDS; n++) begin
            exp_mode.push_back(MODE_WORD);
            exp_word.push_back(fb_model[n]);
            exp_lat.push_back(ref_stream_lat(n));
        end
    endtask

    // Host write, held and retried while the driver owns the RAM
    task automatic write_word(input fb_addr_t addr, input lane_word_t data);
        logic done;
        done = 1'b0;
        host_we = 1'b1;
        host_addr = addr;
        host_wdata = data;
        while (!done) begin
            @(posedge clk);
            done = !host_busy;
            @(negedge clk);
        end
        host_we = 1'b0;
        fb_model[addr] = data;
    endtask

    task automatic wait_enabled(input int n);
        int cnt;
        cnt = 0;
        while (cnt < n) begin
            @(posedge clk);
            if (clk_enable) begin
                cnt++;
            end
        end
        @(negedge clk);
    endtask

    task automatic wait_drained();
        while (exp_mode.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic start_slice();
        push_slice();
        shown_cnt = 0;
        rows_seen = 0;
        position_sync = 1'b1;
        @(negedge clk);
        position_sync = 1'b0;
    endtask

    // Shift edges against the expected queue
    always @(posedge clk) begin : shift_monitor
        int mode;
        lane_word_t word;
        logic lat;
        if (nrst && drv_sclk) begin
            if (exp_mode.size() == 0) begin
                report_failure($sformatf("%s: shift edge while no shift was expected",
                                         test_name));
            end else begin
                mode = exp_mode.pop_front();
                word = exp_word.pop_front();
                lat = exp_lat.pop_front();
                if (mode == MODE_WORD) begin
                    check_lane($sformatf("word %0d", shown_cnt), word, drv_sin);
                    shown_cnt++;
                end else if (mode == MODE_CONF) begin
                    for (int lane = 0; lane < LANES; lane++) begin
                        check_conf_bit($sformatf("conf lane %0d", lane), word[lane],
                                       drv_sin[lane]);
                    end
                end
                check_level("LAT", lat, drv_lat);
            end
        end
    end

    // Each new row must follow an all-off gap and come in order
    always @(posedge clk) begin : row_monitor
        if (nrst && row_en != prev_row && row_en != '0) begin
            check_rows("row break", '0, prev_row);
            check_rows("row order", ref_row(rows_seen), row_en);
            rows_seen = rows_seen + 1;
        end
        prev_row = row_en;
        if (idle_watch) begin
            check_level("GCLK stopped", 1'b0, drv_gclk);
            check_rows("rows off", '0, row_en);
        end
    end

    always @(posedge clk) begin : run_limit
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles, the run did not complete",
                                     cycle_cnt));
        end
    end

    initial begin
        void'($urandom(30));
        nrst = 1'b0;
        position_sync = 1'b0;
        conf_load = 1'b0;
        conf_data = '0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        push_boot(BOOT_CONF);
        repeat (3) @(negedge clk);
        check_level("SCLK in reset", 1'b0, drv_sclk);
        check_level("GCLK in reset", 1'b0, drv_gclk);
        check_level("LAT in reset", 1'b0, drv_lat);
        check_level("busy in reset", 1'b0, host_busy);
        check_lane("SIN in reset", '0, drv_sin);
        check_rows("rows in reset", '0, row_en);
        nrst = 1'b1;

        // Boot config runs while the host loads the slice
        test_name = "boot and load";
        for (int i = 0; i < FB_WORDS; i++) begin
            write_word(fb_addr_t'(i), lane_word_t'($urandom()));
        end
        wait_drained();
        wait_enabled(WRTFC_WAIT + 2);

        // Rewrite the lower half behind the stream
        test_name = "slice A";
        start_slice();
        while (shown_cnt <= FB_WORDS / 2) begin
            @(negedge clk);
        end
        for (int i = 0; i < FB_WORDS / 2; i++) begin
            write_word(fb_addr_t'(i), lane_word_t'($urandom()));
        end
        wait_drained();
        if (rows_seen != ROWS) begin
            report_failure($sformatf("%s: only %0d of %0d rows were enabled",
                                     test_name, rows_seen, ROWS));
        end

        // GCLK stops one segment wrap after the slice
        test_name = "idle";
        wait_enabled(SEG_LAST + 2 * GROUP_LEN);
        idle_watch = 1'b1;
        repeat (100) @(negedge clk);
        idle_watch = 1'b0;

        // Reload the conf past the rewritten words
        test_name = "slice B";
        start_slice();
        while (shown_cnt <= FB_WORDS / 2 + 64) begin
            @(negedge clk);
        end
        next_conf = conf_word_t'({$urandom(), $urandom()});
        conf_data = next_conf;
        conf_load = 1'b1;
        @(negedge clk);
        conf_load = 1'b0;
        @(negedge clk);
        // Stream is gone, boot starts over with the new value
        exp_mode.delete();
        exp_word.delete();
        exp_lat.delete();
        test_name = "reconfig";
        push_boot(next_conf);
        wait_drained();
        wait_enabled(WRTFC_WAIT + 2);

        test_name = "slice C";
        start_slice();
        wait_drained();
        if (rows_seen != ROWS) begin
            report_failure($sformatf("%s: only %0d of %0d rows were enabled",
                                     test_name, rows_seen, ROWS));
        end

        $display("All tests passed!");
        $finish;
    end

endmodule
